//--- fcs_checker.sv
`timescale 1ns/1ps

module fcs_checker
    import frame_pkg::*;
(
    input   logic       clock,
    input   logic       rst_n,
    input   byte_t      byte_data,
    input   logic       byte_valid,
    input   logic       frame_end,
    input   logic       frame_error,

    output  logic       frame_good,
    output  logic       frame_bad
);

crc_t   crc;
crc_t   crc_next;
logic   crc_match;

// Eight reflected CRC steps, LSB of the byte first
function automatic crc_t crc_fold(input crc_t crc_in, input byte_t data);
    crc_t value;
    value = crc_in ^ {24'd0, data};
    for (int bit_index = 0; bit_index < 8; bit_index++) begin
        if (value[0]) begin
            value = (value >> 1) ^ CRC_POLY;
        end else begin
            value = value >> 1;
        end
    end
    return value;
endfunction

assign crc_next  = crc_fold(crc, byte_data);
assign crc_match = (crc == CRC_RESIDUE);

always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
        crc        <= CRC_INIT;
        frame_good <= 1'b0;
        frame_bad  <= 1'b0;
    end else begin
        frame_good <= 1'b0;
        frame_bad  <= 1'b0;

        if (frame_end) begin
            // Verdict and reload for the next frame
            frame_good <= crc_match && !frame_error;
            frame_bad  <= !(crc_match && !frame_error);
            crc        <= CRC_INIT;
        end else if (byte_valid) begin
            crc <= crc_next;
        end
    end
end

endmodule

//--- frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer
    import frame_pkg::*;
#(
    parameter int BUFFER_DEPTH = 64
)(
    input   logic       clock,
    input   logic       rst_n,
    input   byte_t      byte_data,
    input   logic       byte_valid,
    input   logic       frame_end,
    input   logic       frame_good,
    input   logic       frame_bad,
    input   logic       receive_data_enable,

    output  rx_word_t   receive_data,
    output  logic       receive_data_valid
);

localparam int PTR_WIDTH = $clog2(BUFFER_DEPTH);

// Extra top bit tells full from empty
typedef logic [PTR_WIDTH:0] ptr_t;

rx_word_t   memory [BUFFER_DEPTH];

ptr_t       read_pointer;
ptr_t       commit_pointer;
ptr_t       write_pointer;
ptr_t       used_words;

byte_t      pending_byte;
logic       pending_valid;
logic       overflow;

logic       buffer_full;
logic       write_request;
logic       write_enable;
rx_word_t   write_word;
logic       read_pop;

////////////////////////////////////////
// Write side
////////////////////////////////////////

// Counts speculative words too
assign used_words    = write_pointer - read_pointer;
assign buffer_full   = used_words[PTR_WIDTH];

// Held byte goes out when its successor or the frame end shows up
assign write_request = pending_valid && (byte_valid || frame_end);
assign write_enable  = write_request && !buffer_full && !overflow;
assign write_word    = {frame_end, pending_byte};

always_ff @(posedge clock) begin
    if (byte_valid) begin
        pending_byte <= byte_data;
    end
end

always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
        pending_valid <= 1'b0;
    end else if (frame_end) begin
        pending_valid <= 1'b0;
    end else if (byte_valid) begin
        pending_valid <= 1'b1;
    end
end

always_ff @(posedge clock) begin
    if (write_enable) begin
        memory[write_pointer[PTR_WIDTH-1:0]] <= write_word;
    end
end

////////////////////////////////////////
// Pointers and frame rollback
////////////////////////////////////////

always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
        read_pointer   <= '0;
        commit_pointer <= '0;
        write_pointer  <= '0;
        overflow       <= 1'b0;
    end else begin
        if (read_pop) begin
            read_pointer <= read_pointer + 1'b1;
        end

        if (frame_good && !overflow) begin
            commit_pointer <= write_pointer;
            overflow       <= 1'b0;
        end else if (frame_good || frame_bad) begin
            // Bad or truncated frame is dropped whole
            write_pointer <= commit_pointer;
            overflow      <= 1'b0;
        end else begin
            if (write_enable) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (write_request && buffer_full) begin
                overflow <= 1'b1;
            end
        end
    end
end

////////////////////////////////////////
// Read side
////////////////////////////////////////

// Only committed words are visible
assign receive_data_valid = (read_pointer != commit_pointer);
assign receive_data       = memory[read_pointer[PTR_WIDTH-1:0]];
assign read_pop           = receive_data_enable && receive_data_valid;

endmodule

//--- frame_pkg.sv
package frame_pkg;

    ////////////////////////////////////////
    // Frame data
    ////////////////////////////////////////

    typedef logic [7:0] byte_t;

    // Bit 8 flags the last byte of a frame
    typedef logic [8:0] rx_word_t;

    ////////////////////////////////////////
    // Ethernet FCS
    ////////////////////////////////////////

    typedef logic [31:0] crc_t;

    // Reflected form of 0x04C11DB7
    localparam crc_t CRC_POLY    = 32'hEDB88320;
    localparam crc_t CRC_INIT    = 32'hFFFFFFFF;

    // Register value once a good frame and its FCS have passed
    localparam crc_t CRC_RESIDUE = 32'hDEBB20E3;

endpackage

//--- rmii_dibit_assembler.sv
`timescale 1ns/1ps

module rmii_dibit_assembler
    import rmii_pkg::*;
    import frame_pkg::*;
(
    input   logic       clock,
    input   logic       rst_n,
    input   dibit_t     rmii_receive_data,
    input   logic       rmii_receive_data_enable,
    input   logic       rmii_receive_data_error,

    output  byte_t      byte_data,
    output  logic       byte_valid,
    output  logic       frame_end,
    output  logic       frame_error
);

assembler_state_t   state;
logic   [1:0]       dibit_count;
logic               error_seen;

////////////////////////////////////////
// Byte shift register
////////////////////////////////////////

// New dibit enters at the top, so the first one ends up in bits 1:0
always_ff @(posedge clock) begin
    if ((state == DATA) && rmii_receive_data_enable) begin
        byte_data <= {rmii_receive_data, byte_data[7:2]};
    end
end

////////////////////////////////////////
// Frame FSM
////////////////////////////////////////

always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
        state       <= HUNT;
        dibit_count <= 2'd0;
        error_seen  <= 1'b0;
        byte_valid  <= 1'b0;
        frame_end   <= 1'b0;
        frame_error <= 1'b0;
    end else begin
        byte_valid <= 1'b0;
        frame_end  <= 1'b0;

        case (state)
            HUNT: begin
                if (rmii_receive_data_enable) begin
                    error_seen <= rmii_receive_data_error;
                    if (rmii_receive_data == DIBIT_PREAMBLE) begin
                        state <= PREAMBLE;
                    end else begin
                        state <= DISCARD;
                    end
                end
            end

            PREAMBLE: begin
                if (!rmii_receive_data_enable) begin
                    // Carrier lost before the delimiter
                    state <= HUNT;
                end else begin
                    if (rmii_receive_data_error) begin
                        error_seen <= 1'b1;
                    end
                    if (rmii_receive_data == DIBIT_SFD) begin
                        state       <= DATA;
                        dibit_count <= 2'd0;
                    end else if (rmii_receive_data != DIBIT_PREAMBLE) begin
                        state <= DISCARD;
                    end
                end
            end

            DATA: begin
                if (rmii_receive_data_enable) begin
                    dibit_count <= dibit_count + 2'd1;
                    if (dibit_count == 2'd3) begin
                        byte_valid <= 1'b1;
                    end
                    if (rmii_receive_data_error) begin
                        error_seen <= 1'b1;
                    end
                end else begin
                    frame_end   <= 1'b1;
                    // Partial byte at the end counts as an error
                    frame_error <= error_seen || (dibit_count != 2'd0);
                    state       <= HUNT;
                end
            end

            DISCARD: begin
                if (!rmii_receive_data_enable) begin
                    state <= HUNT;
                end
            end

            default: begin
                state <= HUNT;
            end
        endcase
    end
end

endmodule

//--- rmii_pkg.sv
package rmii_pkg;

    ////////////////////////////////////////
    // RMII line level
    ////////////////////////////////////////

    // One RMII data dibit
    // The low pair of each byte goes first on the line
    typedef logic [1:0] dibit_t;

    // Preamble byte 0x55 as seen on the line
    localparam dibit_t DIBIT_PREAMBLE = 2'b01;

    // Last dibit of the delimiter 0xD5
    localparam dibit_t DIBIT_SFD = 2'b11;

    ////////////////////////////////////////
    // Receive assembler FSM
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        HUNT     = 2'd0,
        PREAMBLE = 2'd1,
        DATA     = 2'd2,
        DISCARD  = 2'd3
    } assembler_state_t;

endpackage

//--- rmii_rx_port.sv
`timescale 1ns/1ps

module rmii_rx_port
    import rmii_pkg::*;
    import frame_pkg::*;
#(
    parameter int BUFFER_DEPTH = 64
)(
    input   logic       clock,
    input   logic       rst_n,
    input   dibit_t     rmii_receive_data,
    input   logic       rmii_receive_data_enable,
    input   logic       rmii_receive_data_error,
    input   logic       receive_data_enable,

    output  rx_word_t   receive_data,
    output  logic       receive_data_valid
);

byte_t      byte_data;
logic       byte_valid;
logic       frame_end;
logic       frame_error;
logic       frame_good;
logic       frame_bad;

// Line to bytes
rmii_dibit_assembler u_rmii_dibit_assembler (
    .clock                      (clock),
    .rst_n                      (rst_n),
    .rmii_receive_data          (rmii_receive_data),
    .rmii_receive_data_enable   (rmii_receive_data_enable),
    .rmii_receive_data_error    (rmii_receive_data_error),

    .byte_data                  (byte_data),
    .byte_valid                 (byte_valid),
    .frame_end                  (frame_end),
    .frame_error                (frame_error)
);

fcs_checker u_fcs_checker (
    .clock                      (clock),
    .rst_n                      (rst_n),
    .byte_data                  (byte_data),
    .byte_valid                 (byte_valid),
    .frame_end                  (frame_end),
    .frame_error                (frame_error),

    .frame_good                 (frame_good),
    .frame_bad                  (frame_bad)
);

// Holds each frame until its verdict
frame_buffer #(
    .BUFFER_DEPTH               (BUFFER_DEPTH)
) u_frame_buffer (
    .clock                      (clock),
    .rst_n                      (rst_n),
    .byte_data                  (byte_data),
    .byte_valid                 (byte_valid),
    .frame_end                  (frame_end),
    .frame_good                 (frame_good),
    .frame_bad                  (frame_bad),
    .receive_data_enable        (receive_data_enable),

    .receive_data               (receive_data),
    .receive_data_valid         (receive_data_valid)
);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the RMII receive testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG" build.log
verilator --binary --timing -f sim.f --top-module tb_rmii_rx_port > build.log 2>&1 \
    && ./obj_dir/Vtb_rmii_rx_port > "$LOG" 2>&1 \
    || { echo "Build or simulation run failed"; cat build.log "$LOG" 2>/dev/null; exit 1; }
cat "$LOG"
grep -q "Simulation finished: FAIL" "$LOG" && { echo "Result: failed"; exit 1; }
grep -q "Simulation finished: PASS" "$LOG" || { echo "Result: no result line found"; exit 1; }
echo "Result: passed"

//--- rx_port_checker.sv
`timescale 1ns/1ps

module rx_port_checker
    import rmii_pkg::*;
    import frame_pkg::*;
#(
    parameter int BUFFER_DEPTH = 64
)(
    input   logic       clock,
    input   logic       rst_n,
    input   dibit_t     rmii_receive_data,
    input   logic       rmii_receive_data_enable,
    input   logic       rmii_receive_data_error,
    input   logic       receive_data_enable,
    input   rx_word_t   receive_data,
    input   logic       receive_data_valid,
    input   int         test_id,
    input   logic       test_end,

    output  int         error_count,
    output  int         words_checked,
    output  int         frames_delivered,
    output  int         frames_dropped
);

localparam int LINE_IDLE     = 0;
localparam int LINE_PREAMBLE = 1;
localparam int LINE_DATA     = 2;
localparam int LINE_DISCARD  = 3;

int         line_state = LINE_IDLE;
int         dibit_count = 0;
int         byte_count = 0;
logic       line_error = 1'b0;
logic       overflow = 1'b0;
logic       stray_active = 1'b0;
byte_t      current_byte = 8'h00;
byte_t      frame_bytes [0:255];
rx_word_t   expected_words [$];
int         errors = 0;
int         words = 0;
int         delivered = 0;
int         dropped = 0;
int         test_start_errors = 0;
int         test_start_words = 0;

assign error_count      = errors;
assign words_checked    = words;
assign frames_delivered = delivered;
assign frames_dropped   = dropped;

// Reference CRC-32 is reflected, starts at all ones and is inverted at the end
function automatic logic fcs_matches(input int length);
    crc_t crc;
    crc_t received;
    crc = 32'hFFFFFFFF;
    for (int i = 0; i < length - 4; i++) begin
        crc = crc ^ {24'd0, frame_bytes[i]};
        for (int b = 0; b < 8; b++) begin
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
        end
    end
    // FCS goes out low byte first
    received = {frame_bytes[length-1], frame_bytes[length-2],
                frame_bytes[length-3], frame_bytes[length-4]};
    return (~crc) == received;
endfunction

////////////////////////////////////////
// Buffer space model
////////////////////////////////////////

// Writing the previous byte needs room beyond the unread words and this frame
task automatic note_write();
    if (byte_count > 0 && expected_words.size() + byte_count - 1 >= BUFFER_DEPTH) begin
        overflow = 1'b1;
    end
endtask

task automatic finish_frame();
    logic keep;
    rx_word_t word;
    keep = !line_error && dibit_count == 0 && byte_count >= 4 && byte_count <= 256;
    if (keep) begin
        keep = fcs_matches(byte_count) && !overflow;
    end
    if (keep) begin
        for (int i = 0; i < byte_count; i++) begin
            word = {(i == byte_count - 1), frame_bytes[i]};
            expected_words.push_back(word);
        end
        delivered++;
    end else begin
        dropped++;
    end
endtask

task automatic decode_line();
    if (rmii_receive_data_enable) begin
        case (line_state)
            LINE_IDLE: begin
                line_error = rmii_receive_data_error;
                line_state = (rmii_receive_data == 2'b01) ? LINE_PREAMBLE : LINE_DISCARD;
            end
            LINE_PREAMBLE: begin
                line_error = line_error | rmii_receive_data_error;
                if (rmii_receive_data == 2'b11) begin
                    line_state  = LINE_DATA;
                    dibit_count = 0;
                    byte_count  = 0;
                    overflow    = 1'b0;
                end else if (rmii_receive_data != 2'b01) begin
                    line_state = LINE_DISCARD;
                end
            end
            LINE_DATA: begin
                line_error   = line_error | rmii_receive_data_error;
                current_byte = {rmii_receive_data, current_byte[7:2]};
                dibit_count++;
                if (dibit_count == 4) begin
                    dibit_count = 0;
                    note_write();
                    if (byte_count < 256) begin
                        frame_bytes[byte_count] = current_byte;
                    end
                    byte_count++;
                end
            end
            default: begin
            end
        endcase
    end else begin
        if (line_state == LINE_DATA) begin
            note_write();
            finish_frame();
        end
        line_state = LINE_IDLE;
    end
endtask

task automatic check_output();
    rx_word_t expected;
    if (receive_data_valid && expected_words.size() == 0) begin
        if (!stray_active) begin
            $display("Test %0d: output word 0x%03h appeared while no frame was expected",
                     test_id, receive_data);
            errors++;
        end
        stray_active = 1'b1;
    end else begin
        stray_active = 1'b0;
        if (receive_data_valid && receive_data_enable) begin
            expected = expected_words.pop_front();
            if (receive_data !== expected) begin
                $display("CHECK FAILED receive_data: expected 0x%03h, got 0x%03h",
                         expected, receive_data);
                errors++;
            end
            words++;
        end
    end
endtask

task automatic report_test();
    if (expected_words.size() != 0) begin
        $display("Test %0d: %0d expected words were never read from the DUT",
                 test_id, expected_words.size());
        errors++;
        expected_words.delete();
    end
    $display("Test %0d done: %0d words checked, %0d errors",
             test_id, words - test_start_words, errors - test_start_errors);
    test_start_words  = words;
    test_start_errors = errors;
endtask

// Outputs are handled first so a pop in this cycle counts before the line is judged
always @(posedge clock) begin
    if (!rst_n) begin
        line_state   = LINE_IDLE;
        stray_active = 1'b0;
        expected_words.delete();
    end else begin
        check_output();
        decode_line();
        if (test_end) begin
            report_test();
        end
    end
end

endmodule

//--- sim.f
rmii_pkg.sv
frame_pkg.sv
rmii_dibit_assembler.sv
fcs_checker.sv
frame_buffer.sv
rmii_rx_port.sv
rx_port_checker.sv
tb_rmii_rx_port.sv

//--- tb_rmii_rx_port.sv
`timescale 1ns/1ps

module tb_rmii_rx_port
    import rmii_pkg::*;
    import frame_pkg::*;
();

localparam int BUFFER_DEPTH = 64;
localparam int IDLE_GAP     = 48;

logic       clock = 1'b0;
logic       rst_n = 1'b0;
dibit_t     rmii_receive_data = 2'b00;
logic       rmii_receive_data_enable = 1'b0;
logic       rmii_receive_data_error = 1'b0;
logic       receive_data_enable = 1'b0;
rx_word_t   receive_data;
logic       receive_data_valid;

int         seed = 32'h6ef1;
logic       read_random = 1'b0;
logic       read_next = 1'b0;
int         test_id = 1;
logic       test_end = 1'b0;
logic       timed_out = 1'b0;
byte_t      payload [0:63];
int         error_count;
int         words_checked;
int         frames_delivered;
int         frames_dropped;

always #50 clock = ~clock;

rmii_rx_port #(
    .BUFFER_DEPTH               (BUFFER_DEPTH)
) u_rmii_rx_port (
    .clock                      (clock),
    .rst_n                      (rst_n),
    .rmii_receive_data          (rmii_receive_data),
    .rmii_receive_data_enable   (rmii_receive_data_enable),
    .rmii_receive_data_error    (rmii_receive_data_error),
    .receive_data_enable        (receive_data_enable),
    .receive_data               (receive_data),
    .receive_data_valid         (receive_data_valid)
);

rx_port_checker #(
    .BUFFER_DEPTH               (BUFFER_DEPTH)
) u_rx_port_checker (
    .clock                      (clock),
    .rst_n                      (rst_n),
    .rmii_receive_data          (rmii_receive_data),
    .rmii_receive_data_enable   (rmii_receive_data_enable),
    .rmii_receive_data_error    (rmii_receive_data_error),
    .receive_data_enable        (receive_data_enable),
    .receive_data               (receive_data),
    .receive_data_valid         (receive_data_valid),
    .test_id                    (test_id),
    .test_end                   (test_end),
    .error_count                (error_count),
    .words_checked              (words_checked),
    .frames_delivered           (frames_delivered),
    .frames_dropped             (frames_dropped)
);

// Core read strobe is drawn on the rising edge
always @(posedge clock) begin : read_draw
    logic [31:0] r;
    r = $random(seed);
    read_next = read_random && r[0];
end

// and driven on the falling one
always @(negedge clock) begin
    receive_data_enable = read_next;
end

function automatic int random_length();
    logic [31:0] r;
    r = $random(seed);
    return 4 + int'(r[15:0]) % 37;
endfunction

// Bit-serial FCS over the payload
function automatic crc_t payload_fcs(input int length);
    crc_t crc;
    logic feedback;
    crc = CRC_INIT;
    for (int i = 0; i < length; i++) begin
        for (int b = 0; b < 8; b++) begin
            feedback = crc[0] ^ payload[i][b];
            crc = {1'b0, crc[31:1]};
            if (feedback) begin
                crc = crc ^ CRC_POLY;
            end
        end
    end
    return ~crc;
endfunction

task automatic send_byte(input byte_t value, input logic error_pulse);
    for (int k = 0; k < 4; k++) begin
        @(negedge clock);
        rmii_receive_data_enable = 1'b1;
        rmii_receive_data        = value[2*k +: 2];
        rmii_receive_data_error  = error_pulse && (k == 1);
    end
endtask

task automatic send_frame(input int length, input logic corrupt_fcs,
                          input int error_byte, input logic extra_dibit);
    crc_t        fcs;
    logic [31:0] r;
    for (int i = 0; i < length; i++) begin
        r = $random(seed);
        payload[i] = r[7:0];
    end
    fcs = payload_fcs(length);
    if (corrupt_fcs) begin
        r = $random(seed);
        fcs = fcs ^ (32'h1 << r[4:0]);
    end
    for (int i = 0; i < 7; i++) begin
        send_byte(8'h55, 1'b0);
    end
    send_byte(8'hD5, 1'b0);
    for (int i = 0; i < length; i++) begin
        send_byte(payload[i], i == error_byte);
    end
    for (int i = 0; i < 4; i++) begin
        send_byte(fcs[8*i +: 8], 1'b0);
    end
    if (extra_dibit) begin
        @(negedge clock);
        rmii_receive_data = 2'b10;
    end
    @(negedge clock);
    rmii_receive_data_enable = 1'b0;
    rmii_receive_data        = 2'b00;
    rmii_receive_data_error  = 1'b0;
    repeat (IDLE_GAP) @(negedge clock);
endtask

// Idle means 8 cycles in a row with no line activity and no word waiting
task automatic wait_for_idle(input int limit);
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    while (quiet < 8 && cycles < limit) begin
        @(negedge clock);
        cycles++;
        if (receive_data_valid || rmii_receive_data_enable) begin
            quiet = 0;
        end else begin
            quiet++;
        end
    end
    if (quiet < 8) begin
        $display("Test %0d: timed out after %0d cycles waiting for the output to drain",
                 test_id, limit);
        timed_out = 1'b1;
    end
endtask

task automatic end_test();
    test_end = 1'b1;
    @(negedge clock);
    test_end = 1'b0;
    test_id++;
endtask

initial begin : main
    int          used;
    int          length;
    logic [31:0] r;
    repeat (5) @(negedge clock);
    rst_n       = 1'b1;
    read_random = 1'b1;
    repeat (4) @(negedge clock);

    ////////////////////////////////////////
    // Good frames and bad ones in between
    ////////////////////////////////////////
    for (int n = 0; n < 8; n++) begin
        send_frame(random_length(), 1'b0, -1, 1'b0);
    end
    wait_for_idle(2000);
    end_test();

    if (!timed_out) begin
        send_frame(random_length(), 1'b0, -1, 1'b0);
        send_frame(random_length(), 1'b1, -1, 1'b0);
        send_frame(random_length(), 1'b0, -1, 1'b0);
        wait_for_idle(2000);
        end_test();
    end

    if (!timed_out) begin
        send_frame(random_length(), 1'b0, -1, 1'b0);
        length = random_length();
        send_frame(length, 1'b0, length / 2, 1'b0);
        send_frame(random_length(), 1'b0, -1, 1'b1);
        send_frame(random_length(), 1'b0, -1, 1'b0);
        wait_for_idle(2000);
        end_test();
    end

    ////////////////////////////////////////
    // Fill with the core stalled
    ////////////////////////////////////////
    if (!timed_out) begin
        read_random = 1'b0;
        used = 0;
        // Last frame of the loop is the one that no longer fits
        do begin
            length = random_length();
            send_frame(length, 1'b0, -1, 1'b0);
            used += length + 4;
        end while (used <= BUFFER_DEPTH);
        send_frame(4, 1'b0, -1, 1'b0);
        read_random = 1'b1;
        wait_for_idle(2000);
        end_test();
    end

    ////////////////////////////////////////
    // Line noise and reset
    ////////////////////////////////////////
    if (!timed_out) begin
        @(negedge clock);
        rmii_receive_data_enable = 1'b1;
        rmii_receive_data        = 2'b01;
        repeat (20) @(negedge clock);
        rmii_receive_data_enable = 1'b0;
        repeat (IDLE_GAP) @(negedge clock);
        rmii_receive_data_enable = 1'b1;
        rmii_receive_data        = 2'b10;
        for (int k = 0; k < 40; k++) begin
            @(negedge clock);
            r = $random(seed);
            rmii_receive_data = r[1:0];
        end
        @(negedge clock);
        rmii_receive_data_enable = 1'b0;
        repeat (IDLE_GAP) @(negedge clock);
        // A committed frame is still unread when reset hits
        read_random = 1'b0;
        send_frame(random_length(), 1'b0, -1, 1'b0);
        rst_n = 1'b0;
        rmii_receive_data_enable = 1'b1;
        for (int k = 0; k < 4; k++) begin
            r = $random(seed);
            rmii_receive_data = r[1:0];
            @(negedge clock);
        end
        rmii_receive_data_enable = 1'b0;
        @(negedge clock);
        rst_n       = 1'b1;
        read_random = 1'b1;
        repeat (IDLE_GAP) @(negedge clock);
        wait_for_idle(200);
        end_test();
    end

    @(negedge clock);
    $display("Tests %0d, words %0d, delivered %0d, dropped %0d, errors %0d",
             test_id - 1, words_checked, frames_delivered, frames_dropped, error_count);
    if (timed_out || error_count != 0) begin
        $display("Simulation finished: FAIL");
    end else begin
        $display("Simulation finished: PASS");
    end
    $finish;
end

endmodule
